// File: ahb_1port.f
hw/ahb_1port_pkg.sv
hw/ahb_grant_stage.sv
hw/ahb_aphase_mux.sv
hw/ahb_dphase_router.sv
hw/ahb_sram_slave.sv
hw/ahb_1port_top.sv
testbench/tb_ahb_1port.sv

// File: Makefile
# Verilator lint and simulation for the single-port AHB-Lite front end

VERILATOR ?= verilator
TOP       ?= tb_ahb_1port
RTL_TOP   ?= ahb_1port_top
FILELIST  ?= ahb_1port.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/ahb_1port_patterns.txt
# name, sides (f fetch, d data, b both, p both with panic), data write flag, data address,
# data write data, fetch address, first side (i or d), expected fetch rdata,
# expected data rdata, expected fetch error, expected data error (addresses are byte addresses)
wr_word4            d 1 00000010 a5a50001 00000000 d 00000000 00000000 0 0
rd_word4_data       d 0 00000010 00000000 00000000 d 00000000 a5a50001 0 0
rd_word4_fetch      f 0 00000000 00000000 00000010 i a5a50001 00000000 0 0
wr_word9            d 1 00000024 5ec0ffee 00000000 d 00000000 00000000 0 0
wr_word20           d 1 00000050 13572468 00000000 d 00000000 00000000 0 0
# 0x700 is outside the error window but aliases memory word 192, the first error word
wr_alias_word192    d 1 00000700 cafe0192 00000000 d 00000000 00000000 0 0
prio_data_first     b 0 00000024 00000000 00000050 d 13572468 5ec0ffee 0 0
prio_panic_first    p 0 00000010 00000000 00000024 i 5ec0ffee a5a50001 0 0
prio_write_vs_fetch b 1 00000030 0badf00d 00000010 d a5a50001 00000000 0 0
rd_word12_fetch     f 0 00000000 00000000 00000030 i 0badf00d 00000000 0 0
panic_vs_write      p 1 00000040 77665544 00000050 i 13572468 00000000 0 0
rd_word16_data      d 0 00000040 00000000 00000000 d 00000000 77665544 0 0
same_word_both      b 0 00000050 00000000 00000050 d 13572468 13572468 0 0
rd_untouched_by_b   b 0 00000030 00000000 00000040 d 77665544 0badf00d 0 0
wr_err_data         d 1 00000300 deadbeef 00000000 d 00000000 00000000 0 1
rd_err_data         d 0 00000304 00000000 00000000 d 00000000 00000000 0 1
rd_err_fetch        f 0 00000000 00000000 00000308 i 00000000 00000000 1 0
err_fetch_panic     p 0 00000024 00000000 0000033c i 00000000 5ec0ffee 1 0
err_data_both       b 1 00000300 deadbeef 00000050 d 13572468 00000000 0 1
rd_alias_after_err  d 0 00000700 00000000 00000000 d 00000000 cafe0192 0 0
rd_above_window     f 0 00000000 00000000 00000340 i 00000000 00000000 0 0
rd_word9_final      b 0 00000024 00000000 00000024 d 5ec0ffee 5ec0ffee 0 0

// File: testbench/tb_ahb_1port.sv
// Testbench for the single-port AHB-Lite front end
// Reads transactions and expected responses from the pattern file
// Drives fetch and load/store sides, checks grant order, routing and latency

`timescale 1ns/1ps

module tb_ahb_1port;

	// Matches the DUT default
	localparam int WAIT_STATES = 1;
	localparam int APH_TIMEOUT = 40;
	localparam int DPH_TIMEOUT = 40;

	logic                             clk;
	logic                             rst_n;
	ahb_1port_pkg::fetch_req_t        fetch_req;
	ahb_1port_pkg::data_req_t         data_req;
	logic [ahb_1port_pkg::W_DATA-1:0] hwdata;
	ahb_1port_pkg::side_rsp_t         rsp_i;
	ahb_1port_pkg::side_rsp_t         rsp_d;

	// Run bookkeeping
	int    tests_run;
	int    tests_failed;
	int    test_errs;
	logic  timed_out;
	string cur_name;

	ahb_1port_top u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_req_i (fetch_req),
		.data_req_i  (data_req),
		.hwdata_i    (hwdata),
		.rsp_i_o     (rsp_i),
		.rsp_d_o     (rsp_d)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------------------------
	// Checking helpers

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR test %s, %s: expected %h, actual %h", cur_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs != 0 || timed_out) begin
			tests_failed++;
			$display("test %s failed with %0d mismatches", cur_name, test_errs);
		end else begin
			$display("test %s passed", cur_name);
		end
	endtask

	// No handshake flags before the first request
	task automatic check_reset_idle();
		cur_name  = "reset_idle";
		test_errs = 0;
		repeat (3) begin
			@(negedge clk);
			check("fetch flags", 32'd0, 32'({rsp_i.aph_ready, rsp_i.dph_ready, rsp_i.dph_err}));
			check("data flags", 32'd0, 32'({rsp_d.aph_ready, rsp_d.dph_ready, rsp_d.dph_err}));
		end
		finish_test();
	endtask

	// ----------------------------------------------------------
	// One transaction per requesting side

	task automatic run_test(
		input logic [7:0]  sides,
		input logic        d_wr,
		input logic [31:0] d_addr,
		input logic [31:0] d_wdata,
		input logic [31:0] i_addr,
		input logic [7:0]  first,
		input logic [31:0] i_exp,
		input logic [31:0] d_exp,
		input logic        i_err,
		input logic        d_err
	);
		// Side state, 0 done, 1 address phase, 2 data phase
		int          st_i;
		int          st_d;
		int          wait_i;
		int          wait_d;
		int          acc_i;
		int          acc_d;
		int          n;
		logic        act_i;
		logic        act_d;
		logic        drop_i;
		logic        drop_d;
		logic        end_d;
		logic        seen_err_i;
		logic        seen_err_d;
		logic [31:0] rd_i;
		logic [31:0] rd_d;
		logic [7:0]  first_seen;
		act_i      = (sides != "d");
		act_d      = (sides != "f");
		st_i       = act_i ? 1 : 0;
		st_d       = act_d ? 1 : 0;
		wait_i     = 0;
		wait_d     = 0;
		acc_i      = 0;
		acc_d      = 0;
		n          = 0;
		seen_err_i = 1'b0;
		seen_err_d = 1'b0;
		rd_i       = '0;
		rd_d       = '0;
		first_seen = "-";
		@(posedge clk);
		fetch_req.req   <= act_i;
		fetch_req.panic <= (sides == "p");
		fetch_req.haddr <= i_addr;
		data_req.req    <= act_d;
		data_req.hwrite <= d_wr;
		data_req.haddr  <= d_addr;
		while ((st_i != 0 || st_d != 0) && !timed_out) begin
			@(negedge clk);
			n++;
			drop_i = 1'b0;
			drop_d = 1'b0;
			end_d  = 1'b0;
			check("aph_ready one-hot", 32'd0, 32'(rsp_i.aph_ready & rsp_d.aph_ready));
			// Fetch side, data phase first so a new acceptance waits a cycle
			if (st_i == 2) begin
				seen_err_i |= rsp_i.dph_err;
				if (rsp_i.dph_ready) begin
					rd_i = rsp_i.rdata;
					check("fetch latency", 32'(WAIT_STATES + (i_err ? 2 : 1)), 32'(n - acc_i));
					st_i = 0;
				end
			end else begin
				check("fetch dph flags", 32'd0, 32'({rsp_i.dph_ready, rsp_i.dph_err}));
			end
			if (st_i == 1) begin
				if (rsp_i.aph_ready) begin
					acc_i  = n;
					st_i   = 2;
					wait_i = 0;
					drop_i = 1'b1;
					if (first_seen == "-") begin
						first_seen = "i";
					end
				end
			end else begin
				check("fetch aph_ready", 32'd0, 32'(rsp_i.aph_ready));
			end
			// Load/store side
			if (st_d == 2) begin
				seen_err_d |= rsp_d.dph_err;
				if (rsp_d.dph_ready) begin
					rd_d  = rsp_d.rdata;
					end_d = 1'b1;
					check("data latency", 32'(WAIT_STATES + (d_err ? 2 : 1)), 32'(n - acc_d));
					st_d  = 0;
				end
			end else begin
				check("data dph flags", 32'd0, 32'({rsp_d.dph_ready, rsp_d.dph_err}));
			end
			if (st_d == 1) begin
				if (rsp_d.aph_ready) begin
					acc_d  = n;
					st_d   = 2;
					wait_d = 0;
					drop_d = 1'b1;
					if (first_seen == "-") begin
						first_seen = "d";
					end
				end
			end else begin
				check("data aph_ready", 32'd0, 32'(rsp_d.aph_ready));
			end
			// Per-side wait limits
			if (st_i != 0) begin
				wait_i++;
			end
			if (st_d != 0) begin
				wait_d++;
			end
			if ((st_i == 1 && wait_i > APH_TIMEOUT) || (st_i == 2 && wait_i > DPH_TIMEOUT)) begin
				$display("test %s timed out waiting on the fetch side in state %0d", cur_name, st_i);
				timed_out = 1'b1;
			end
			if ((st_d == 1 && wait_d > APH_TIMEOUT) || (st_d == 2 && wait_d > DPH_TIMEOUT)) begin
				$display("test %s timed out waiting on the data side in state %0d", cur_name, st_d);
				timed_out = 1'b1;
			end
			@(posedge clk);
			if (drop_i) begin
				fetch_req.req <= 1'b0;
			end
			// Write data rides the data phase
			if (drop_d) begin
				data_req.req <= 1'b0;
				hwdata       <= d_wr ? d_wdata : '0;
			end
			if (end_d) begin
				hwdata <= '0;
			end
		end
		if (!timed_out) begin
			if (act_i && act_d) begin
				check("first side", 32'(first), 32'(first_seen));
			end
			if (act_i) begin
				check("fetch dph_err", 32'(i_err), 32'(seen_err_i));
				if (!i_err) begin
					check("fetch rdata", i_exp, rd_i);
				end
			end
			if (act_d) begin
				check("data dph_err", 32'(d_err), 32'(seen_err_d));
				if (!d_wr && !d_err) begin
					check("data rdata", d_exp, rd_d);
				end
			end
		end
		// Idle cycle between tests
		fetch_req.panic <= 1'b0;
		fetch_req.haddr <= '0;
		data_req.hwrite <= 1'b0;
		data_req.haddr  <= '0;
		@(posedge clk);
	endtask

	// ----------------------------------------------------------
	// Main sequence

	initial begin
		int              fd;
		int              nf;
		string           line;
		logic [8*24-1:0] name_v;
		logic [7:0]      sides_v;
		logic            d_wr_v;
		logic [31:0]     d_addr_v;
		logic [31:0]     d_wdata_v;
		logic [31:0]     i_addr_v;
		logic [7:0]      first_v;
		logic [31:0]     i_exp_v;
		logic [31:0]     d_exp_v;
		logic            i_err_v;
		logic            d_err_v;
		rst_n     <= 1'b0;
		fetch_req <= '{req: 1'b0, panic: 1'b0, hsize: ahb_1port_pkg::HSIZE_WORD, haddr: '0};
		data_req  <= '{req: 1'b0, hwrite: 1'b0, hsize: ahb_1port_pkg::HSIZE_WORD, haddr: '0};
		hwdata    <= '0;
		tests_run    = 0;
		tests_failed = 0;
		test_errs    = 0;
		timed_out    = 1'b0;
		repeat (16) begin
			@(posedge clk);
		end
		rst_n <= 1'b1;
		check_reset_idle();
		fd = $fopen("testbench/ahb_1port_patterns.txt", "r");
		if (fd == 0) begin
			$display("pattern file testbench/ahb_1port_patterns.txt could not be opened");
			tests_failed++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				nf   = $fgets(line, fd);
				// Skip comments and blank lines
				if (line.len() > 1 && line[0] != "#") begin
					name_v = '0;
					nf = $sscanf(line, "%s %s %h %h %h %h %s %h %h %h %h", name_v, sides_v,
						d_wr_v, d_addr_v, d_wdata_v, i_addr_v, first_v, i_exp_v, d_exp_v,
						i_err_v, d_err_v);
					if (nf != 11) begin
						$display("pattern line could not be parsed: %s", line);
						tests_failed++;
					end else begin
						cur_name  = $sformatf("%0s", name_v);
						test_errs = 0;
						run_test(sides_v, d_wr_v, d_addr_v, d_wdata_v, i_addr_v, first_v,
							i_exp_v, d_exp_v, i_err_v, d_err_v);
						finish_test();
					end
				end
			end
			$fclose(fd);
		end
		$display("tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && tests_run > 1 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: hw/ahb_1port_top.sv
// Single-port bus front end with its memory slave
// Grant stage, address-phase mux, data-phase router, SRAM slave

`timescale 1ns/1ps

module ahb_1port_top #(
	parameter int unsigned MEM_WORDS_LOG2 = 8,
	parameter int unsigned WAIT_STATES    = 1,
	parameter int unsigned ERR_BASE       = 192,
	parameter int unsigned ERR_WORDS      = 16
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  ahb_1port_pkg::fetch_req_t        fetch_req_i,
	input  ahb_1port_pkg::data_req_t         data_req_i,
	input  logic [ahb_1port_pkg::W_DATA-1:0] hwdata_i,
	output ahb_1port_pkg::side_rsp_t         rsp_i_o,
	output ahb_1port_pkg::side_rsp_t         rsp_d_o
);

	ahb_1port_pkg::grant_t       grant;
	ahb_1port_pkg::ahb_aph_t     aph;
	ahb_1port_pkg::ahb_slv_rsp_t slv_rsp;

	// Arbitration, held over stalls
	ahb_grant_stage u_grant (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_req_i (fetch_req_i),
		.data_req_i  (data_req_i),
		.hready_i    (slv_rsp.hready),
		.grant_o     (grant)
	);

	// Address phase onto the bus
	ahb_aphase_mux u_aphase (
		.grant_i     (grant),
		.fetch_req_i (fetch_req_i),
		.data_req_i  (data_req_i),
		.aph_o       (aph)
	);

	// Responses back to the owner
	ahb_dphase_router u_dphase (
		.clk       (clk),
		.rst_n     (rst_n),
		.grant_i   (grant),
		.slv_rsp_i (slv_rsp),
		.rsp_i_o   (rsp_i_o),
		.rsp_d_o   (rsp_d_o)
	);

	// Memory on the far side of the port
	ahb_sram_slave #(
		.MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
		.WAIT_STATES    (WAIT_STATES),
		.ERR_BASE       (ERR_BASE),
		.ERR_WORDS      (ERR_WORDS)
	) u_slave (
		.clk      (clk),
		.rst_n    (rst_n),
		.aph_i    (aph),
		.hwdata_i (hwdata_i),
		.rsp_o    (slv_rsp)
	);

endmodule

// File: hw/ahb_sram_slave.sv
// Word-addressed AHB-Lite memory slave
// Fixed wait states before each data phase completes
// Address window that answers with the two-cycle error response

`timescale 1ns/1ps

module ahb_sram_slave #(
	parameter int unsigned MEM_WORDS_LOG2 = 8,
	parameter int unsigned WAIT_STATES    = 1,
	parameter int unsigned ERR_BASE       = 192,
	parameter int unsigned ERR_WORDS      = 16
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  ahb_1port_pkg::ahb_aph_t          aph_i,
	input  logic [ahb_1port_pkg::W_DATA-1:0] hwdata_i,
	output ahb_1port_pkg::ahb_slv_rsp_t      rsp_o
);

	localparam int unsigned W_CNT = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
	localparam logic [W_CNT-1:0] CNT_LOAD = W_CNT'(WAIT_STATES);
	// Error window bounds as word indices
	localparam logic [ahb_1port_pkg::W_ADDR-1:0] ERR_LO = ERR_BASE;
	localparam logic [ahb_1port_pkg::W_ADDR-1:0] ERR_HI = ERR_BASE + ERR_WORDS;

	logic [ahb_1port_pkg::W_DATA-1:0] mem [2**MEM_WORDS_LOG2];

	// Address phase decode
	logic [ahb_1port_pkg::W_ADDR-1:0] aph_word;
	logic                             aph_active;
	logic                             aph_in_err;

	// Data phase state
	logic                      dph_vld;
	logic                      dph_write;
	logic                      dph_err;
	logic                      err_seen;
	logic [W_CNT-1:0]          wait_cnt;
	logic [MEM_WORDS_LOG2-1:0] dph_idx;

	logic stall_wait;
	logic stall_err;
	logic hready;

	// ----------------------------------------------------------
	// Address phase decode

	assign aph_word   = {2'b00, aph_i.haddr[ahb_1port_pkg::W_ADDR-1:2]};
	// Nonseq or seq, bit 1 of htrans
	assign aph_active = aph_i.htrans[1];
	assign aph_in_err = (aph_word >= ERR_LO) && (aph_word < ERR_HI);

	// ----------------------------------------------------------
	// Data phase sequencing

	assign stall_wait = dph_vld && (wait_cnt != '0);
	// First error cycle, hready low with hresp high
	assign stall_err  = dph_vld && (wait_cnt == '0) && dph_err && !err_seen;
	assign hready     = !(stall_wait || stall_err);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_vld   <= 1'b0;
			dph_write <= 1'b0;
			dph_err   <= 1'b0;
			err_seen  <= 1'b0;
			wait_cnt  <= '0;
		end else if (hready) begin
			// Take the next address phase
			dph_vld   <= aph_active;
			dph_write <= aph_i.hwrite;
			dph_err   <= aph_in_err;
			err_seen  <= 1'b0;
			wait_cnt  <= aph_active ? CNT_LOAD : '0;
		end else if (stall_wait) begin
			wait_cnt <= wait_cnt - 1'b1;
		end else begin
			// Second error cycle comes next
			err_seen <= 1'b1;
		end
	end

	// Word index of the data phase
	always_ff @(posedge clk) begin
		if (hready && aph_active) begin
			dph_idx <= aph_i.haddr[MEM_WORDS_LOG2+1:2];
		end
	end

	// ----------------------------------------------------------
	// Memory

	// Write lands on the last data-phase cycle, never in the error window
	always_ff @(posedge clk) begin
		if (dph_vld && hready && dph_write && !dph_err) begin
			mem[dph_idx] <= hwdata_i;
		end
	end

	always_comb begin
		rsp_o.hready = hready;
		rsp_o.hresp  = dph_vld && (wait_cnt == '0) && dph_err;
		rsp_o.hrdata = (dph_vld && !dph_write && !dph_err) ? mem[dph_idx] : '0;
	end

	// ----------------------------------------------------------
	// Checks

	// Error always spans two cycles, hready low first
	a_err_two_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		(rsp_o.hresp && rsp_o.hready) |-> $past(rsp_o.hresp && !rsp_o.hready)
	);

endmodule

// File: hw/ahb_dphase_router.sv
// Data-phase ownership tracking for fetch and load/store
// Routes hready, hresp and read data back to the owning side
// aph_ready follows the grant, dph_ready and dph_err follow ownership

`timescale 1ns/1ps

module ahb_dphase_router (
	input  logic                        clk,
	input  logic                        rst_n,
	input  ahb_1port_pkg::grant_t       grant_i,
	input  ahb_1port_pkg::ahb_slv_rsp_t slv_rsp_i,
	output ahb_1port_pkg::side_rsp_t    rsp_i_o,
	output ahb_1port_pkg::side_rsp_t    rsp_d_o
);

	// Owner of the data phase now on the bus
	logic own_i;
	logic own_d;

	// ----------------------------------------------------------
	// Ownership

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			own_i <= 1'b0;
			own_d <= 1'b0;
		end else if (slv_rsp_i.hready) begin
			// Accepted address phase becomes the next data phase
			own_i <= grant_i.gnt_i;
			own_d <= grant_i.gnt_d;
		end
	end

	// ----------------------------------------------------------
	// Response routing

	// Same gating for either side
	function automatic ahb_1port_pkg::side_rsp_t route(
		input logic                        gnt,
		input logic                        own,
		input ahb_1port_pkg::ahb_slv_rsp_t rsp
	);
		ahb_1port_pkg::side_rsp_t r;
		r.aph_ready = rsp.hready && gnt;
		r.dph_ready = rsp.hready && own;
		// Reported in both error cycles
		// lets the owner squash a trailing access early
		r.dph_err   = own && rsp.hresp;
		// Read data fans out, only the owner samples it
		r.rdata     = rsp.hrdata;
		return r;
	endfunction

	assign rsp_i_o = route(grant_i.gnt_i, own_i, slv_rsp_i);
	assign rsp_d_o = route(grant_i.gnt_d, own_d, slv_rsp_i);

	// ----------------------------------------------------------
	// Checks

	// One data phase in flight, one owner
	a_owner_not_two_hot: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(own_i && own_d)
	);

endmodule

// File: hw/ahb_aphase_mux.sv
// Address-phase mux for the shared AHB-Lite master port
// Turns the granted request into htrans, haddr, hwrite, hsize, hprot

`timescale 1ns/1ps

module ahb_aphase_mux (
	input  ahb_1port_pkg::grant_t     grant_i,
	input  ahb_1port_pkg::fetch_req_t fetch_req_i,
	input  ahb_1port_pkg::data_req_t  data_req_i,
	output ahb_1port_pkg::ahb_aph_t   aph_o
);

	// ----------------------------------------------------------
	// Address phase select

	always_comb begin
		if (grant_i.gnt_d) begin
			// Load/store, read or write
			aph_o.htrans = ahb_1port_pkg::HTRANS_NSEQ;
			aph_o.haddr  = data_req_i.haddr;
			aph_o.hsize  = data_req_i.hsize;
			aph_o.hwrite = data_req_i.hwrite;
			aph_o.hprot  = ahb_1port_pkg::HPROT_DATA;
		end else if (grant_i.gnt_i) begin
			// Opcode fetch, always a read
			aph_o.htrans = ahb_1port_pkg::HTRANS_NSEQ;
			aph_o.haddr  = fetch_req_i.haddr;
			aph_o.hsize  = fetch_req_i.hsize;
			aph_o.hwrite = 1'b0;
			aph_o.hprot  = ahb_1port_pkg::HPROT_INSTR;
		end else begin
			// Bus idle
			// zeroed fields keep the address bus quiet
			aph_o.htrans = ahb_1port_pkg::HTRANS_IDLE;
			aph_o.haddr  = '0;
			aph_o.hsize  = '0;
			aph_o.hwrite = 1'b0;
			aph_o.hprot  = '0;
		end
	end

endmodule

// File: hw/ahb_grant_stage.sv
// Arbiter between fetch and load/store requesters
// Grant held over a stalled address phase
// Priority is panic fetch, then data, then fetch

`timescale 1ns/1ps

module ahb_grant_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	input  ahb_1port_pkg::fetch_req_t fetch_req_i,
	input  ahb_1port_pkg::data_req_t  data_req_i,
	input  logic                      hready_i,
	output ahb_1port_pkg::grant_t     grant_o
);

	// Address phase went out while the bus was stalled
	logic                  hold_aph;
	// Grant from the previous cycle
	ahb_1port_pkg::grant_t gnt_prev;
	// Grant for this cycle
	ahb_1port_pkg::grant_t gnt;
	logic                  gnt_any;

	assign gnt_any = gnt.gnt_i || gnt.gnt_d;

	// ----------------------------------------------------------
	// Hold state

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_aph <= 1'b0;
			gnt_prev <= '0;
		end else begin
			// AHB needs the address phase kept until hready
			hold_aph <= gnt_any && !hready_i;
			gnt_prev <= gnt;
		end
	end

	// ----------------------------------------------------------
	// Priority select

	always_comb begin
		gnt = '0;
		if (hold_aph) begin
			// Stalled phase keeps its owner
			gnt = gnt_prev;
		end else if (fetch_req_i.req && fetch_req_i.panic) begin
			// Fetch panic beats data
			gnt.gnt_i = 1'b1;
		end else if (data_req_i.req) begin
			gnt.gnt_d = 1'b1;
		end else if (fetch_req_i.req) begin
			gnt.gnt_i = 1'b1;
		end
	end

	assign grant_o = gnt;

	// ----------------------------------------------------------
	// Checks

	// Never both sides on the bus at once
	a_grant_not_two_hot: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(gnt.gnt_i && gnt.gnt_d)
	);

endmodule

// File: hw/ahb_1port_pkg.sv
// Widths and AHB-Lite encodings for the single-port bus front end
// Request structs from the fetch and load/store sides
// Address-phase, slave response and per-side response structs
// One-hot grant struct

package ahb_1port_pkg;

	// ----------------------------------------------------------
	// Widths

	localparam int W_ADDR = 32;
	localparam int W_DATA = 32;

	// ----------------------------------------------------------
	// AHB-Lite encodings

	// Only single transfers, so idle and nonseq are enough
	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_NSEQ = 2'b10;

	// Noncacheable nonbufferable privileged
	// bit 0 tells data from opcode fetch
	localparam logic [3:0] HPROT_DATA  = 4'b0011;
	localparam logic [3:0] HPROT_INSTR = 4'b0010;

	// Byte count as log2, word is 4 bytes
	localparam logic [2:0] HSIZE_WORD  = 3'b010;

	// ----------------------------------------------------------
	// Requester side

	// Fetch side, read only
	typedef struct packed {
		logic              req;
		logic              panic;
		logic [2:0]        hsize;
		logic [W_ADDR-1:0] haddr;
	} fetch_req_t;

	// Load/store side
	typedef struct packed {
		logic              req;
		logic              hwrite;
		logic [2:0]        hsize;
		logic [W_ADDR-1:0] haddr;
	} data_req_t;

	// Handshake and read data back to one requester
	typedef struct packed {
		logic              aph_ready;
		logic              dph_ready;
		logic              dph_err;
		logic [W_DATA-1:0] rdata;
	} side_rsp_t;

	// At most one bit set
	typedef struct packed {
		logic gnt_i;
		logic gnt_d;
	} grant_t;

	// ----------------------------------------------------------
	// Bus side

	// Master address phase
	typedef struct packed {
		logic [1:0]        htrans;
		logic [W_ADDR-1:0] haddr;
		logic              hwrite;
		logic [2:0]        hsize;
		logic [3:0]        hprot;
	} ahb_aph_t;

	// Slave data-phase response
	typedef struct packed {
		logic              hready;
		logic              hresp;
		logic [W_DATA-1:0] hrdata;
	} ahb_slv_rsp_t;

endpackage
